// ==== source/mem_pkg.sv ====
package mem_pkg;

    // bank geometry, one bank is 2048 x 32 bit (8 KiB)
    localparam int MEM_DEPTH  = 2048;
    localparam int WORD_W     = 32;
    localparam int WADDR_W    = $clog2(MEM_DEPTH);           // 11 bit word address
    localparam int BYTE_SEL_W = 2;                            // byte offset bits, ignored
    localparam int BUS_ADDR_W = WADDR_W + BYTE_SEL_W + 1;     // word addr + offset + bank bit
    localparam int BANK_BIT   = BUS_ADDR_W - 1;               // msb of the apb byte address

    // bank select values seen on paddr[BANK_BIT]
    localparam logic BANK_OUT = 1'b0;   // bus writes, fabric reads
    localparam logic BANK_IN  = 1'b1;   // fabric writes, bus reads only

    // one memory word
    typedef logic [WORD_W-1:0] word_t;

    // word address inside a bank
    typedef logic [WADDR_W-1:0] word_addr_t;

    // apb byte address
    // [13]   bank select
    // [12:2] word address
    // [1:0]  ignored, no sub-word access
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

endpackage

// ==== source/vec_pkg.sv ====
package vec_pkg;
    import mem_pkg::*;

    // fabric vector length in words, kept well below MEM_DEPTH
    localparam int VLEN = 8;

    // cycles per sweep, has to be larger than VLEN + 2 so the
    // read pipeline and the done pulse fit inside one period
    localparam int SCAN_PERIOD = 64;

    localparam int VEC_W = VLEN * WORD_W;          // 256 bit vector
    localparam int CNT_W = $clog2(SCAN_PERIOD);    // 6 bit sweep counter

    // word k sits at bits [32k +: 32]
    typedef logic [VEC_W-1:0] vec_t;

    // free running sweep position, 0 .. SCAN_PERIOD-1
    typedef logic [CNT_W-1:0] scan_cnt_t;

    // counter values both engines compare against
    localparam scan_cnt_t CNT_LAST = scan_cnt_t'(SCAN_PERIOD - 1);  // wrap point
    localparam scan_cnt_t CNT_VLEN = scan_cnt_t'(VLEN);             // first count past the words

endpackage

// ==== source/bram_if.sv ====
`timescale 1ns/10ps

// one port of a block memory
// rdata follows an enabled read access by one cycle
interface bram_if import mem_pkg::*; ();

    logic       en;     // port enable
    logic       we;     // write when en is high, read otherwise
    word_addr_t addr;   // word address
    word_t      wdata;
    word_t      rdata;  // registered in the memory

    // side that issues accesses
    modport user (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // side that holds the array
    modport mem (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== source/dual_port_bram.sv ====
`timescale 1ns/10ps

// true dual port block memory, MEM_DEPTH words of word_t
// both ports share clk, read latency is one cycle on each
module dual_port_bram
    import mem_pkg::*;
(
    input logic  clk,
    bram_if.mem  a,     // bus side
    bram_if.mem  b      // fabric side
);

    word_t ram [MEM_DEPTH];  // storage shared by both ports

    // each port reads or writes one word per cycle
    always_ff @(posedge clk) begin
        // port a
        if (a.en) begin
            if (a.we) begin
                ram[a.addr] <= a.wdata;
            end else begin
                a.rdata <= ram[a.addr];  // valid in the next cycle
            end
        end

        // port b
        if (b.en) begin
            if (b.we) begin
                ram[b.addr] <= b.wdata;
            end else begin
                b.rdata <= ram[b.addr];
            end
        end
    end

    // rdata holds its last value while the port is idle or writing,
    // so a consumer can sample it late without harm

endmodule

// ==== source/bram_to_vector.sv ====
`timescale 1ns/10ps

// sweeps the first VLEN words of the output bank over and over
// and lays them side by side in out_vec
//
// count k (k < VLEN)  read word k
// count k+1           word k arrives, slice k loaded at the end of the cycle
// count VLEN+1        sweep_done, every slice holds this sweep's word
module bram_to_vector
    import mem_pkg::*, vec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    bram_if.user  mem,          // port b of the output bank, read only
    output vec_t  out_vec,
    output logic  sweep_done
);

    scan_cnt_t  cnt;        // sweep position
    logic       rd_pend;    // a read was issued last cycle
    word_addr_t rd_slot;    // slice index of that read

    // free running sweep counter
    // the wrap back to zero doubles as the periodic restart
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one read per cycle while inside the vector
    assign mem.en    = (cnt < CNT_VLEN);
    assign mem.we    = 1'b0;                // this port never writes
    assign mem.addr  = word_addr_t'(cnt);   // word k at count k
    assign mem.wdata = '0;

    // returning word goes to the slice of the address that fetched it,
    // rd_slot lags the address by exactly the memory latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend    <= 1'b0;
            rd_slot    <= '0;
            out_vec    <= '0;
            sweep_done <= 1'b0;
        end else begin
            rd_pend <= mem.en;
            rd_slot <= mem.addr;
            if (rd_pend) begin
                out_vec[rd_slot*WORD_W +: WORD_W] <= mem.rdata;
            end
            // last slice lands at the end of count VLEN,
            // so the pulse covers count VLEN+1
            sweep_done <= (cnt == CNT_VLEN);
        end
    end

endmodule

// ==== source/vector_to_bram.sv ====
`timescale 1ns/10ps

// captures in_vec once per sweep period and stores it word by word
// into the input bank
//
// count 0         snapshot of in_vec
// count k+1       slice k written to word k (k < VLEN)
// count VLEN+1    capture_done, all words of this snapshot are in memory
module vector_to_bram
    import mem_pkg::*, vec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  vec_t  in_vec,
    bram_if.user  mem,          // port b of the input bank, write only
    output logic  capture_done
);

    scan_cnt_t cnt;     // sweep position
    scan_cnt_t slot;    // slice written in this cycle
    vec_t      snap;    // all stored words come from this one sample

    // free running sweep counter, same period as the output sweep
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // sample the whole fabric vector at once
    always_ff @(posedge clk) begin
        if (cnt == '0) begin
            snap <= in_vec;
        end
    end

    assign slot = cnt - 1'b1;  // one behind the counter

    // write one slice per cycle during counts 1 .. VLEN
    assign mem.en    = (cnt != '0) && (cnt <= CNT_VLEN);
    assign mem.we    = mem.en;                       // port never reads
    assign mem.addr  = word_addr_t'(slot);
    assign mem.wdata = snap[slot*WORD_W +: WORD_W];  // only used while en

    // last write happens in count VLEN, memory holds it from VLEN+1
    always_ff @(posedge clk) begin
        if (rst) begin
            capture_done <= 1'b0;
        end else begin
            capture_done <= (cnt == CNT_VLEN);
        end
    end

endmodule

// ==== source/apb_bram_bridge.sv ====
`timescale 1ns/10ps

// apb completer in front of port a of both banks
//
// write  setup, access (pready high, word written at the end of it)
// read   setup, access (memory read, pready low),
//        access (pready high, prdata from the memory register)
// a write to the input bank is refused with pslverr and not performed
module apb_bram_bridge
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  bus_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    bram_if.user      out_bank,     // port a of the output bank
    bram_if.user      in_bank       // port a of the input bank
);

    typedef enum logic [1:0] {
        IDLE,       // waiting for setup or a write access
        RD_WAIT,    // first access cycle of a read, memory access issued
        RD_DONE     // second access cycle, data on prdata
    } state_t;

    state_t     state;
    logic       bank;       // bank select of the current transfer
    logic       rd_bank;    // bank the pending read went to
    logic       wr_acc;     // write access cycle
    logic       rd_acc;     // read issued this cycle
    word_addr_t waddr;

    assign bank   = paddr[BANK_BIT];
    assign waddr  = paddr[BANK_BIT-1:BYTE_SEL_W];  // byte offset dropped
    assign wr_acc = (state == IDLE) && psel && penable && pwrite;
    assign rd_acc = (state == RD_WAIT);

    // reads advance from the setup cycle, writes finish in IDLE
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            rd_bank <= BANK_OUT;
        end else begin
            case (state)
                IDLE: if (psel && !penable && !pwrite) state <= RD_WAIT;
                RD_WAIT: begin
                    state   <= RD_DONE;
                    rd_bank <= bank;     // picks the rdata in RD_DONE
                end
                default: state <= IDLE;  // RD_DONE, transfer over
            endcase
        end
    end

    // output bank, read and write
    assign out_bank.en    = (wr_acc || rd_acc) && (bank == BANK_OUT);
    assign out_bank.we    = wr_acc;
    assign out_bank.addr  = waddr;
    assign out_bank.wdata = pwdata;

    // input bank, read only from the bus
    assign in_bank.en    = rd_acc && (bank == BANK_IN);
    assign in_bank.we    = 1'b0;
    assign in_bank.addr  = waddr;
    assign in_bank.wdata = pwdata;

    assign pready  = wr_acc || (state == RD_DONE);
    assign pslverr = wr_acc && (bank == BANK_IN);   // write protection
    assign prdata  = (rd_bank == BANK_IN) ? in_bank.rdata : out_bank.rdata;

endmodule

// ==== source/vec_mem_top.sv ====
`timescale 1ns/10ps

// vector exchange between an apb bus and the fabric
//
// output bank  bus writes over port a, bram_to_vector sweeps port b
// input bank   vector_to_bram writes port b, bus reads port a
module vec_mem_top
    import mem_pkg::*, vec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // apb completer
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  bus_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,

    // fabric side
    input  vec_t      in_vec,
    output vec_t      out_vec,
    output logic      sweep_done,      // out_vec complete for this sweep
    output logic      capture_done     // in_vec snapshot stored
);

    bram_if out_a_if ();   // bridge to output bank
    bram_if in_a_if ();    // bridge to input bank
    bram_if out_b_if ();   // sweep reader
    bram_if in_b_if ();    // capture writer

    apb_bram_bridge bridge (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .out_bank (out_a_if.user),
        .in_bank  (in_a_if.user)
    );

    dual_port_bram out_bank_mem (.clk(clk), .a(out_a_if.mem), .b(out_b_if.mem));

    dual_port_bram in_bank_mem (.clk(clk), .a(in_a_if.mem), .b(in_b_if.mem));

    bram_to_vector sweep (
        .clk        (clk),
        .rst        (rst),
        .mem        (out_b_if.user),
        .out_vec    (out_vec),
        .sweep_done (sweep_done)
    );

    vector_to_bram capture (
        .clk          (clk),
        .rst          (rst),
        .in_vec       (in_vec),
        .mem          (in_b_if.user),
        .capture_done (capture_done)
    );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/10ps

// testbench clock and reset source
module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_NS    = 4;  // 8 ns period
    localparam int RST_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // high for the first four rising edges, dropped on the falling edge after them
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tb/tb_vec_mem.sv ====
`timescale 1ns/10ps

module tb_vec_mem
    import mem_pkg::*, vec_pkg::*;
();

    localparam int unsigned SEED = 32'hf829_42ca;
    localparam int CLK_NS  = 8;
    localparam int N_RAND  = 24;   // random writes to the output bank, each read back
    localparam int N_FAR   = 4;    // writes above the swept words
    localparam int N_APB   = 2 * N_RAND + VLEN + N_FAR + 2 * VLEN + 2;
    localparam int WDOG_NS = 2 * (N_APB * 4 + 12 * SCAN_PERIOD) * CLK_NS;

    logic clk, rst;
    logic psel, penable, pwrite;
    bus_addr_t paddr;
    word_t pwdata, prdata;
    logic pready, pslverr;
    vec_t in_vec, out_vec;
    logic sweep_done, capture_done;

    word_t model [2][MEM_DEPTH];   // both banks, indexed by the bank bit
    int sweep_gap = 0;
    int capture_gap = 0;
    int sweep_seen = 0;
    int capture_seen = 0;

    clk_gen clocks (.clk(clk), .rst(rst));

    vec_mem_top uut (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .in_vec(in_vec), .out_vec(out_vec),
        .sweep_done(sweep_done), .capture_done(capture_done)
    );

    task automatic stop_sim();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        stop_sim();
    endtask

    task automatic check_word(input string what, input int idx, input word_t got,
                              input word_t exp);
        assert (got === exp) else report_error($sformatf("%s %0d is %08h, expected %08h",
                                                         what, idx, got, exp));
    endtask

    // sample a quarter period after the falling edge, well clear of both edges
    task automatic wait_ready();
        int waits;
        waits = 0;
        #2;
        while (!pready) begin
            if (waits == 3) begin
                $display("apb transfer got no pready within 3 wait states at %0d ns", $time);
                stop_sim();
            end
            @(negedge clk);
            #2;
            waits++;
        end
    endtask

    task automatic write_word(input logic bank, input int addr, input word_t data,
                              input logic exp_err);
        logic err;
        @(negedge clk);                                      // setup
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = {bank, word_addr_t'(addr), 2'($urandom)};  // offset bits are don't care
        pwdata  = data;
        @(negedge clk);                                      // access
        penable = 1'b1;
        wait_ready();
        err = pslverr;
        assert (err == exp_err) else report_error(
            $sformatf("pslverr %0b on write to bank %0b word %0d", err, bank, addr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_word(input logic bank, input int addr, output word_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = {bank, word_addr_t'(addr), 2'($urandom)};
        @(negedge clk);
        penable = 1'b1;
        wait_ready();
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // count pulses of sweep_done (sel 0) or capture_done (sel 1)
    task automatic wait_pulses(input logic sel, input int count);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count) begin
            @(negedge clk);
            cycles++;
            if (sel ? capture_done : sweep_done) seen++;
            if (cycles > count * SCAN_PERIOD + 4) begin
                $display("no %s pulse within %0d cycles", sel ? "capture" : "sweep", cycles);
                stop_sim();
            end
        end
    endtask

    task automatic check_out_vec();
        for (int k = 0; k < VLEN; k++) begin
            check_word("out_vec slice", k, out_vec[k*WORD_W +: WORD_W], model[BANK_OUT][k]);
        end
    endtask

    function automatic vec_t random_vec();
        vec_t v;
        for (int k = 0; k < VLEN; k++) v[k*WORD_W +: WORD_W] = $urandom;
        return v;
    endfunction

    // apb timing, sampled on the rising edge
    assert property (@(posedge clk) disable iff (rst) psel && penable && pwrite |-> pready)
        else report_error("write access cycle without pready");
    assert property (@(posedge clk) disable iff (rst)
                     psel && penable && !pwrite && !$past(penable) |-> !pready)
        else report_error("read completed without its wait state");
    assert property (@(posedge clk) disable iff (rst)
                     psel && penable && !pwrite && $past(penable) |-> pready)
        else report_error("read not done in its second access cycle");
    assert property (@(posedge clk) disable iff (rst)
                     pslverr |-> psel && penable && pwrite && paddr[BANK_BIT])
        else report_error("pslverr outside a refused write");
    assert property (@(posedge clk) disable iff (rst)
                     psel && penable && pwrite && paddr[BANK_BIT] |-> pslverr)
        else report_error("input bank write completed without pslverr");
    assert property (@(posedge clk) disable iff (rst) sweep_done |=> !sweep_done)
        else report_error("sweep_done longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) capture_done |=> !capture_done)
        else report_error("capture_done longer than one cycle");

    // pulse spacing, gap counted in cycles since the previous pulse
    always @(negedge clk) begin
        sweep_gap++;
        capture_gap++;
        if (sweep_done) begin
            if (sweep_seen > 0)
                assert (sweep_gap == SCAN_PERIOD) else report_error(
                    $sformatf("sweep_done %0d cycles after the previous one", sweep_gap));
            sweep_seen++;
            sweep_gap = 0;
        end
        if (capture_done) begin
            if (capture_seen > 0)
                assert (capture_gap == SCAN_PERIOD) else report_error(
                    $sformatf("capture_done %0d cycles after the previous one", capture_gap));
            capture_seen++;
            capture_gap = 0;
        end
    end

    initial begin
        #(WDOG_NS);
        $display("timeout after %0d ns, the tests did not finish", WDOG_NS);
        stop_sim();
    end

    initial begin
        int wr_addr [$];
        int a;
        word_t d;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        in_vec  = '0;
        void'($urandom(SEED));

        // reset and the first cycle after it
        @(posedge clk);
        repeat (5) begin
            @(negedge clk);
            assert (!pready && !pslverr && !sweep_done && !capture_done && out_vec == '0)
                else report_error("outputs not idle during reset");
        end

        // random writes with some repeated addresses, then read back
        for (int i = 0; i < N_RAND; i++) begin
            if (i % 4 == 3) a = wr_addr[$];                // overwrite the previous word
            else a = int'($urandom % MEM_DEPTH);
            d = $urandom;
            write_word(BANK_OUT, a, d, 1'b0);
            model[BANK_OUT][a] = d;
            wr_addr.push_back(a);
        end
        foreach (wr_addr[i]) begin
            read_word(BANK_OUT, wr_addr[i], d);
            check_word("output bank word", wr_addr[i], d, model[BANK_OUT][wr_addr[i]]);
        end

        // swept words reach out_vec
        for (int k = 0; k < VLEN; k++) begin
            d = $urandom;
            write_word(BANK_OUT, k, d, 1'b0);
            model[BANK_OUT][k] = d;
        end
        wait_pulses(1'b0, 2);
        check_out_vec();

        // words above the vector leave out_vec alone
        for (int i = 0; i < N_FAR; i++) begin
            a = (i == 0) ? VLEN : VLEN + int'($urandom % (MEM_DEPTH - VLEN));
            d = $urandom;
            write_word(BANK_OUT, a, d, 1'b0);
            model[BANK_OUT][a] = d;
        end
        wait_pulses(1'b0, 2);
        check_out_vec();

        // capture of two different input vectors
        repeat (2) begin
            @(negedge clk);
            in_vec = random_vec();
            for (int k = 0; k < VLEN; k++) model[BANK_IN][k] = in_vec[k*WORD_W +: WORD_W];
            wait_pulses(1'b1, 2);
            for (int k = 0; k < VLEN; k++) begin
                read_word(BANK_IN, k, d);
                check_word("input bank word", k, d, model[BANK_IN][k]);
            end
        end

        // refused write, placed right after a capture so no capture write follows it
        wait_pulses(1'b1, 1);
        a = int'($urandom % VLEN);
        write_word(BANK_IN, a, $urandom, 1'b1);
        read_word(BANK_IN, a, d);
        check_word("protected input bank word", a, d, model[BANK_IN][a]);

        if (sweep_seen >= 2 && capture_seen >= 2) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("too few sweep or capture pulses to check their spacing");
            stop_sim();
        end
    end

endmodule

// ==== tb.f ====
source/mem_pkg.sv
source/vec_pkg.sv
source/bram_if.sv
source/dual_port_bram.sv
source/bram_to_vector.sv
source/vector_to_bram.sv
source/apb_bram_bridge.sv
source/vec_mem_top.sv
tb/clk_gen.sv
tb/tb_vec_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vec_mem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_vec_mem -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vec_mem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
